// ==== filelist.f ====
logic/pp_pkg.sv
logic/pp_sram.sv
logic/pp_fill_counter.sv
logic/pp_bank_fsm.sv
logic/pp_read_port.sv
logic/pp_buffer_top.sv
testbench/tb_pp_buffer.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the frame buffer testbench with Verilator.
# Exit status is 0 only when the pass line shows up in the simulator output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
  --top-module tb_pp_buffer -f filelist.f -o tb_pp_buffer_sim \
  && ./obj_dir/tb_pp_buffer_sim | tee /dev/stderr \
     | grep -x "Finished with no errors" > /dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

exit 0

// ==== testbench/tb_pp_buffer.sv ====
// ping-pong frame buffer testbench with stimulus, reference model, comparator and watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_pp_buffer;

  import pp_pkg::*;

  localparam int CLK_HALF_NS = 2;   // 4 ns period
  localparam int RST_CYCLES  = 4;
  localparam int NUM_FRAMES  = 4;   // frame budget for watchdog
  localparam int WATCHDOG_NS = NUM_FRAMES * FRAME_DEPTH * 4 * 4 * 2;  // about 100 us
  localparam int HOLD_CYCLES = 20;  // stall window while fill bank is full
  localparam int READY_WAIT  = 64;  // cycles allowed for frame ready to rise

  // one outstanding read tagged with its frame
  typedef struct packed {
    logic [3:0]        frame;
    logic [ADDR_W-1:0] addr;
  } pend_t;

  logic    clk;
  logic    rst_n;
  logic    wr_valid;
  pix_t    wr_data;
  logic    wr_ready;
  logic    rd_req_valid;
  rd_req_t rd_req;
  logic    rd_req_ready;
  logic    rd_rsp_valid;
  rd_rsp_t rd_rsp;
  logic    rd_rsp_ready;
  logic    rel_pulse;      // engine release
  logic    frame_ready;

  logic [31:0]       lcg_state;
  logic [31:0]       coin;                             // back-pressure draw
  int                error_count;
  int                wr_beats;                         // accepted beats, all frames
  int                rsp_seen;                         // taken responses
  int                cur_read_frame;                   // frame in read bank
  logic              backpressure;                     // random rsp ready when set
  logic [PIX_W-1:0]  pix_log [NUM_FRAMES*FRAME_DEPTH]; // write sequence
  pend_t             pend_q [$];                       // requests in order
  pend_t             pend_new;
  pend_t             pend_head;
  logic              held_valid;                       // stalled last cycle
  pix_t              held_pix;
  logic [ADDR_W-1:0] perm [FRAME_DEPTH];               // read order

  pp_buffer_top u_pp_buffer_top (
    .i_clk_input    (clk),
    .i_rst_n        (rst_n),
    .i_wr_valid     (wr_valid),
    .i_wr_data      (wr_data),
    .o_wr_ready     (wr_ready),
    .i_rd_req_valid (rd_req_valid),
    .i_rd_req       (rd_req),
    .o_rd_req_ready (rd_req_ready),
    .o_rd_rsp_valid (rd_rsp_valid),
    .o_rd_rsp       (rd_rsp),
    .i_rd_rsp_ready (rd_rsp_ready),
    .i_release      (rel_pulse),
    .o_frame_ready  (frame_ready)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF_NS clk = ~clk;
  end

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;  // 32 bit LCG
    return lcg_state;
  endfunction

  // frames logged back to back from frame 1
  function automatic logic [PIX_W-1:0] expected_pixel(input int frame, input int addr);
    return pix_log[(frame - 1) * FRAME_DEPTH + addr];
  endfunction

  //////////////////////////////////////////////////
  // comparator sampled at rising edge
  //////////////////////////////////////////////////
  always @(posedge clk) begin
    if (rst_n) begin
      if (wr_valid && wr_ready && wr_beats < NUM_FRAMES * FRAME_DEPTH) begin
        pix_log[wr_beats] = wr_data.value;  // log accepted beat
        wr_beats++;
      end
      if (held_valid) begin
        if (!rd_rsp_valid) begin
          $display("A response was dropped while the consumer stalled at %0t", $time);
          error_count++;
        end else if (rd_rsp.pix != held_pix) begin
          $display("** Error at %0t: held response changed from %h to %h",
                   $time, held_pix.value, rd_rsp.pix.value);
          error_count++;
        end
      end
      if (rd_rsp_valid && rd_rsp_ready) begin
        if (pend_q.size() == 0) begin
          $display("A response arrived with no outstanding request at %0t", $time);
          error_count++;
        end else begin
          pend_head = pend_q.pop_front();  // oldest request
          if (rd_rsp.pix.value !== expected_pixel(int'(pend_head.frame),
                                                  int'(pend_head.addr))) begin
            $display("** Error at %0t: frame %0d addr %0d read %h, expected %h",
                     $time, pend_head.frame, pend_head.addr, rd_rsp.pix.value,
                     expected_pixel(int'(pend_head.frame), int'(pend_head.addr)));
            error_count++;
          end
        end
        rsp_seen++;
      end
      if (rd_req_valid && rd_req_ready) begin
        pend_new.frame = 4'(cur_read_frame);
        pend_new.addr  = rd_req.addr;
        pend_q.push_back(pend_new);
      end
      held_valid = rd_rsp_valid && !rd_rsp_ready;
      held_pix   = rd_rsp.pix;
    end
  end

  // consumer ready is random only while enabled
  always @(negedge clk) begin
    if (backpressure) begin
      coin         = next_rand();
      rd_rsp_ready = coin[27];
    end else begin
      rd_rsp_ready = 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // stimulus tasks
  //////////////////////////////////////////////////
  task automatic write_frame();
    logic [31:0] r;
    int          gap;
    for (int a = 0; a < FRAME_DEPTH; a++) begin
      r   = next_rand();
      gap = int'(r[31:30]) % 3;  // 0..2 idle cycles
      @(negedge clk);
      wr_valid = 1'b0;
      repeat (gap) @(negedge clk);
      wr_valid      = 1'b1;
      wr_data.value = r[23:16];
      @(posedge clk);
      while (!wr_ready) @(posedge clk);  // beat taken here
    end
    @(negedge clk);
    wr_valid = 1'b0;
  endtask

  // random read order for the next frame
  task automatic shuffle_read_order();
    logic [31:0]       r;
    logic [ADDR_W-1:0] t;
    int                j;
    for (int i = 0; i < FRAME_DEPTH; i++) begin
      perm[i] = ADDR_W'(i);
    end
    for (int i = FRAME_DEPTH - 1; i > 0; i--) begin
      r       = next_rand();
      j       = int'(r[31:16]) % (i + 1);  // shuffle step
      t       = perm[i];
      perm[i] = perm[j];
      perm[j] = t;
    end
  endtask

  task automatic read_frame(input int frame, input logic use_bp);
    int target;
    cur_read_frame = frame;
    backpressure   = use_bp;
    target         = rsp_seen + FRAME_DEPTH;
    @(negedge clk);
    for (int i = 0; i < FRAME_DEPTH; i++) begin
      rd_req_valid = 1'b1;
      rd_req.addr  = perm[i];
      @(posedge clk);
      while (!rd_req_ready) @(posedge clk);
      @(negedge clk);
    end
    rd_req_valid = 1'b0;
    while (rsp_seen < target) @(negedge clk);  // drain all responses
    @(posedge clk);
    backpressure = 1'b0;
  endtask

  task automatic pulse_release();
    @(negedge clk);
    rel_pulse = 1'b1;
    @(negedge clk);
    rel_pulse = 1'b0;
  endtask

  task automatic wait_frame_ready(input string what);
    int n;
    n = 0;
    @(posedge clk);
    while (!frame_ready && n < READY_WAIT) begin
      @(posedge clk);
      n++;
    end
    if (!frame_ready) begin
      $display("The frame ready flag never rose %s", what);
      error_count++;
    end
  endtask

  // full fill bank must refuse beats until release
  task automatic check_write_hold();
    @(negedge clk);
    wr_valid      = 1'b1;
    wr_data.value = 8'hA5;
    repeat (HOLD_CYCLES) begin
      @(posedge clk);
      if (wr_ready) begin
        $display("A write was accepted while the fill bank was full at %0t", $time);
        error_count++;
      end
      if (!frame_ready) begin
        $display("The read bank was freed without a release at %0t", $time);
        error_count++;
      end
    end
    @(negedge clk);
    wr_valid = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////
  initial begin
    lcg_state      = 32'd97130;
    error_count    = 0;
    wr_beats       = 0;
    rsp_seen       = 0;
    cur_read_frame = 0;
    backpressure   = 1'b0;
    held_valid     = 1'b0;
    held_pix       = '0;
    rst_n          = 1'b0;
    wr_valid       = 1'b0;
    wr_data        = '0;
    rd_req_valid   = 1'b0;
    rd_req         = '0;
    rd_rsp_ready   = 1'b1;
    rel_pulse      = 1'b0;
    repeat (RST_CYCLES) @(negedge clk);
    rst_n        = 1'b1;
    rd_req_valid = 1'b1;  // refused while no frame is present
    @(posedge clk);
    if (wr_ready || rd_req_ready || rd_rsp_valid || frame_ready) begin
      $display("Outputs were not all low right after reset");
      error_count++;
    end
    repeat (8) begin
      @(posedge clk);
      if (rd_req_ready) begin
        $display("A read request was allowed with no frame present at %0t", $time);
        error_count++;
      end
    end
    if (!wr_ready) begin
      $display("Write ready did not rise after reset");
      error_count++;
    end
    @(negedge clk);
    rd_req_valid = 1'b0;

    write_frame();                           // frame 1 into a free read bank
    wait_frame_ready("after frame 1");
    shuffle_read_order();
    read_frame(1, 1'b0);
    write_frame();                           // frame 2 while frame 1 held
    check_write_hold();
    pulse_release();
    wait_frame_ready("after frame 1 release");
    shuffle_read_order();
    fork
      write_frame();                         // frame 3 overlaps frame 2 reads
      read_frame(2, 1'b1);
    join
    pulse_release();
    wait_frame_ready("after frame 2 release");
    shuffle_read_order();
    read_frame(3, 1'b1);
    pulse_release();
    repeat (4) @(negedge clk);

    if (pend_q.size() != 0) begin
      $display("Some read requests never got a response");
      error_count++;
    end
    if (wr_beats != 3 * FRAME_DEPTH || rsp_seen != 3 * FRAME_DEPTH) begin
      $display("Beat counts are off: %0d writes, %0d responses", wr_beats, rsp_seen);
      error_count++;
    end
    if (frame_ready) begin
      $display("The frame ready flag stayed high after the last release");
      error_count++;
    end
    $display("Error count: %0d", error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // watchdog
  initial begin
    #WATCHDOG_NS;
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/pp_buffer_top.sv ====
// ping-pong frame buffer top with fill counter, bank FSM, two banks and read port
`timescale 1ns/1ps
`default_nettype none

module pp_buffer_top (
  input  logic                 i_clk_input,
  input  logic                 i_rst_n,
  // loader write stream
  input  logic                 i_wr_valid,
  input  pp_pkg::pix_t         i_wr_data,
  output logic                 o_wr_ready,
  // engine read request
  input  logic                 i_rd_req_valid,
  input  pp_pkg::rd_req_t      i_rd_req,
  output logic                 o_rd_req_ready,
  // engine read response
  output logic                 o_rd_rsp_valid,
  output pp_pkg::rd_rsp_t      o_rd_rsp,
  input  logic                 i_rd_rsp_ready,
  // control and status
  input  logic                 i_release,       // engine frees read bank
  output logic                 o_frame_ready    // read bank holds a frame
);

  import pp_pkg::*;

  logic              wr_allow;   // FSM write permission
  logic              wr_fire;    // beat accepted
  logic [ADDR_W-1:0] fill_addr;  // fill bank write address
  logic              fill_full;
  logic              fill_clear;
  logic              bank_sel;   // fill bank index
  logic              read_sel;   // read bank index
  logic              rd_en;      // read strobe from port
  logic [ADDR_W-1:0] rd_addr;
  pix_t              rd_data;    // read bank output

  logic [1:0]        bank_en;
  logic [1:0]        bank_we;
  logic [ADDR_W-1:0] bank_addr [2];
  pix_t              bank_rdata [2];

  assign wr_fire    = i_wr_valid && wr_allow;
  assign o_wr_ready = wr_allow;
  assign read_sel   = ~bank_sel;  // the other bank

  //////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////
  pp_fill_counter u_fill_counter (
    .i_clk_input (i_clk_input),
    .i_rst_n     (i_rst_n),
    .i_clear     (fill_clear),
    .i_inc       (wr_fire),
    .o_addr      (fill_addr),
    .o_full      (fill_full)
  );

  pp_bank_fsm u_bank_fsm (
    .i_clk_input   (i_clk_input),
    .i_rst_n       (i_rst_n),
    .i_full        (fill_full),
    .i_release     (i_release),
    .o_bank_sel    (bank_sel),
    .o_wr_allow    (wr_allow),
    .o_clear       (fill_clear),
    .o_frame_ready (o_frame_ready)
  );

  //////////////////////////////////////////////////
  // bank steering
  //////////////////////////////////////////////////
  always_comb begin
    bank_en             = '0;
    bank_we             = '0;
    bank_addr[0]        = rd_addr;
    bank_addr[1]        = rd_addr;
    bank_en[bank_sel]   = wr_fire;    // fill bank writes
    bank_we[bank_sel]   = wr_fire;
    bank_addr[bank_sel] = fill_addr;
    bank_en[read_sel]   = rd_en;      // read bank reads
  end

  assign rd_data = bank_rdata[read_sel];

  pp_sram u_bank0 (
    .i_clk_input (i_clk_input),
    .i_en        (bank_en[0]),
    .i_we        (bank_we[0]),
    .i_addr      (bank_addr[0]),
    .i_wdata     (i_wr_data),
    .o_rdata     (bank_rdata[0])
  );

  pp_sram u_bank1 (
    .i_clk_input (i_clk_input),
    .i_en        (bank_en[1]),
    .i_we        (bank_we[1]),
    .i_addr      (bank_addr[1]),
    .i_wdata     (i_wr_data),
    .o_rdata     (bank_rdata[1])
  );

  //////////////////////////////////////////////////
  // engine side
  //////////////////////////////////////////////////
  pp_read_port u_read_port (
    .i_clk_input    (i_clk_input),
    .i_rst_n        (i_rst_n),
    .i_frame_ready  (o_frame_ready),
    .i_rd_req_valid (i_rd_req_valid),
    .i_rd_req       (i_rd_req),
    .o_rd_req_ready (o_rd_req_ready),
    .o_bank_en      (rd_en),
    .o_bank_addr    (rd_addr),
    .i_bank_rdata   (rd_data),
    .o_rd_rsp_valid (o_rd_rsp_valid),
    .o_rd_rsp       (o_rd_rsp),
    .i_rd_rsp_ready (i_rd_rsp_ready)
  );

endmodule

`default_nettype wire

// ==== logic/pp_read_port.sv ====
// engine read port with request acceptance, bank read and held response
`timescale 1ns/1ps
`default_nettype none

module pp_read_port (
  input  logic                      i_clk_input,
  input  logic                      i_rst_n,
  input  logic                      i_frame_ready,   // read bank occupied
  input  logic                      i_rd_req_valid,
  input  pp_pkg::rd_req_t           i_rd_req,
  output logic                      o_rd_req_ready,
  output logic                      o_bank_en,       // read strobe to read bank
  output logic [pp_pkg::ADDR_W-1:0] o_bank_addr,
  input  pp_pkg::pix_t              i_bank_rdata,    // one cycle after strobe
  output logic                      o_rd_rsp_valid,
  output pp_pkg::rd_rsp_t           o_rd_rsp,
  input  logic                      i_rd_rsp_ready
);

  import pp_pkg::*;

  logic accept;       // request transfer
  logic rsp_valid_q;  // response pending
  logic fresh_q;      // bank data arrives this cycle
  pix_t hold_q;       // copy of bank data while stalled

  // room when empty or being drained now
  assign o_rd_req_ready = i_frame_ready && (!rsp_valid_q || i_rd_rsp_ready);
  assign accept         = i_rd_req_valid && o_rd_req_ready;

  assign o_bank_en   = accept;          // one pulse per request
  assign o_bank_addr = i_rd_req.addr;

  //////////////////////////////////////////////////
  // response control
  //////////////////////////////////////////////////
  always_ff @(posedge i_clk_input) begin
    if (!i_rst_n) begin
      rsp_valid_q <= 1'b0;
      fresh_q     <= 1'b0;
    end else begin
      fresh_q <= accept;  // sram output lands next cycle
      if (accept) begin
        rsp_valid_q <= 1'b1;  // new one replaces taken one
      end else if (i_rd_rsp_ready) begin
        rsp_valid_q <= 1'b0;  // taken, nothing behind it
      end
    end
  end

  // capture data as it arrives
  always_ff @(posedge i_clk_input) begin
    if (fresh_q) begin
      hold_q <= i_bank_rdata;
    end
  end

  // first cycle straight from sram, then from hold reg
  always_comb begin
    o_rd_rsp.pix = fresh_q ? i_bank_rdata : hold_q;
  end

  assign o_rd_rsp_valid = rsp_valid_q;

endmodule

`default_nettype wire

// ==== logic/pp_bank_fsm.sv ====
// bank controller FSM with select, write permission and read-bank occupancy
`timescale 1ns/1ps
`default_nettype none

module pp_bank_fsm (
  input  logic i_clk_input,
  input  logic i_rst_n,
  input  logic i_full,         // fill bank complete
  input  logic i_release,      // engine done with read bank
  output logic o_bank_sel,     // 0: bank0 fills, bank1 read
  output logic o_wr_allow,     // loader may write
  output logic o_clear,        // restart fill counter
  output logic o_frame_ready   // read bank holds a frame
);

  import pp_pkg::*;

  bank_state_e state_q;     // current state
  bank_state_e state_d;     // next state
  logic        run_q;       // low during reset, high after
  logic        occupied_q;  // read bank in use by engine
  logic        sel_q;       // fill bank index
  logic        read_free;   // read bank free now or this edge

  // a release arriving with full also counts as free
  assign read_free = !occupied_q || i_release;

  //////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      FILL: begin
        if (i_full) begin
          state_d = read_free ? SWAP : HOLD;  // swap at once if possible
        end
      end
      HOLD: begin
        if (read_free) begin
          state_d = SWAP;  // release seen
        end
      end
      SWAP: begin
        state_d = FILL;  // swap lasts one cycle
      end
      default: begin
        state_d = FILL;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // state, select and occupancy
  //////////////////////////////////////////////////
  always_ff @(posedge i_clk_input) begin
    if (!i_rst_n) begin
      state_q    <= FILL;
      run_q      <= 1'b0;
      occupied_q <= 1'b0;
      sel_q      <= 1'b0;
    end else begin
      state_q <= state_d;
      run_q   <= 1'b1;  // writes open one cycle after reset
      if (state_q == SWAP) begin
        sel_q      <= ~sel_q;  // full bank becomes read bank
        occupied_q <= 1'b1;    // engine now owns it
      end else if (i_release) begin
        occupied_q <= 1'b0;    // ignored if already free
      end
    end
  end

  // outputs
  assign o_bank_sel    = sel_q;
  assign o_wr_allow    = run_q && (state_q == FILL) && !i_full;  // drops in HOLD
  assign o_clear       = (state_q == SWAP);
  assign o_frame_ready = occupied_q;

endmodule

`default_nettype wire

// ==== logic/pp_fill_counter.sv ====
// fill bank write-address counter with full flag and clear
`timescale 1ns/1ps
`default_nettype none

module pp_fill_counter (
  input  logic                      i_clk_input,
  input  logic                      i_rst_n,
  input  logic                      i_clear,   // back to 0 on swap
  input  logic                      i_inc,     // accepted write beat
  output logic [pp_pkg::ADDR_W-1:0] o_addr,    // next write address
  output logic                      o_full     // frame complete
);

  import pp_pkg::*;

  logic [ADDR_W-1:0] count_q;  // beats written so far
  logic              full;     // count at frame depth

  assign full = (count_q == ADDR_W'(FRAME_DEPTH));  // 768 fits in ADDR_W

  //////////////////////////////////////////////////
  // count
  //////////////////////////////////////////////////
  always_ff @(posedge i_clk_input) begin
    if (!i_rst_n) begin
      count_q <= '0;
    end else if (i_clear) begin
      count_q <= '0;  // new fill bank starts empty
    end else if (i_inc && !full) begin
      count_q <= count_q + 1'b1;  // saturates at depth
    end
  end

  assign o_addr = count_q;  // beat goes to current count
  assign o_full = full;

endmodule

`default_nettype wire

// ==== logic/pp_sram.sv ====
// single-port bank memory with registered read data
`timescale 1ns/1ps
`default_nettype none

module pp_sram (
  input  logic                      i_clk_input,
  input  logic                      i_en,       // port enable
  input  logic                      i_we,       // write when enabled
  input  logic [pp_pkg::ADDR_W-1:0] i_addr,
  input  pp_pkg::pix_t              i_wdata,
  output pp_pkg::pix_t              o_rdata     // valid one cycle after read
);

  import pp_pkg::*;

  pix_t mem [FRAME_DEPTH];  // one frame of pixels

  // write or registered read, never both
  always_ff @(posedge i_clk_input) begin
    if (i_en) begin
      if (i_we) begin
        mem[i_addr] <= i_wdata;  // store pixel
      end else begin
        o_rdata <= mem[i_addr];  // read into output reg
      end
    end
  end

  // o_rdata keeps its last value while idle

endmodule

`default_nettype wire

// ==== logic/pp_pkg.sv ====
// frame geometry, pixel and read structs, bank controller states
`default_nettype none

package pp_pkg;

  //////////////////////////////////////////////////
  // frame geometry
  //////////////////////////////////////////////////
  localparam int FRAME_DEPTH = 768;  // pixels per frame
  localparam int ADDR_W      = 10;   // wide enough to hold FRAME_DEPTH itself
  localparam int PIX_W       = 8;    // grey level pixel

  //////////////////////////////////////////////////
  // payload structs
  //////////////////////////////////////////////////

  // one pixel, also the bank word
  typedef struct packed {
    logic [PIX_W-1:0] value;  // intensity
  } pix_t;

  // engine read request
  typedef struct packed {
    logic [ADDR_W-1:0] addr;  // pixel index in read bank
  } rd_req_t;

  // engine read response
  typedef struct packed {
    pix_t pix;  // pixel at requested addr
  } rd_rsp_t;

  //////////////////////////////////////////////////
  // bank controller
  //////////////////////////////////////////////////
  typedef enum logic [1:0] {
    FILL = 2'd0,  // loader writes fill bank
    HOLD = 2'd1,  // fill bank full, read bank busy
    SWAP = 2'd2   // one cycle bank exchange
  } bank_state_e;

endpackage

`default_nettype wire
